// ==== test/agnus_vectors.mem ====
// test cnt chan(dsk aud bpl spr cop blt) wr(dsk blt) cpu(aen rd hwr lwr) misc(bls turbo busy zero)
// adin dain dblt | grant(dbr dbwe aspr acop ablt ecop eblt) aout rout dout hpos beam(sol den pau)
1 1 000000 00 1010 0000 4b 87e0 0000 0000011 00000 4b 0000 000 000
1 1 000000 00 0000 0000 00 0000 0000 1000010 00000 ff 0000 001 000
1 1 000000 00 1100 0010 01 0000 0000 0000011 00000 01 47e0 002 000
// priority, channels drop out one by one
2 1 111111 11 0000 0000 00 0000 0000 1100000 10001 10 0000 003 000
2 1 011111 11 0000 0000 00 0000 0000 1000000 20002 20 0000 004 000
2 1 011111 11 0000 0000 00 0000 0000 1000000 00000 ff 0000 005 000
2 1 001111 11 0000 0000 00 0000 0000 1000000 30003 30 0000 006 000
2 1 000111 11 0000 0000 00 0000 0000 1000010 00000 ff 0000 007 000
2 1 000111 11 0000 0000 00 0000 0000 1010010 40004 40 0000 008 000
2 1 000011 11 0000 0000 00 0000 0000 1001010 50005 50 0000 009 000
2 1 000001 11 0000 0000 00 0000 0000 1100111 60006 60 0000 00a 000
// cpu register address pass-through
3 1 000000 00 1100 0000 3c 0000 0000 0000011 00000 3c 0000 00b 010
3 1 000000 00 1000 0000 3c 0000 0000 0000011 00000 ff 0000 00c 000
3 1 000000 00 0100 0000 3c 0000 0000 0000011 00000 ff 0000 00d 001
3 1 000000 00 1001 0000 3c 0000 0000 0000011 00000 3c 0000 00e 000
4 1 000000 00 1010 0000 4b 0400 0000 0000011 00000 4b 0000 00f 000
4 1 000000 00 1100 0001 01 0000 0008 0000011 00000 01 23e8 010 000
// slowdown counts on even slots only
5 1 000001 00 0000 1000 00 0000 0000 1000111 60006 60 0000 011 000
5 5 000001 00 0000 1000 00 0000 0000 1000111 60006 60 0000 016 000
5 1 000001 00 0000 1000 00 0000 0000 0000010 00000 ff 0000 017 000
5 1 000001 00 0000 0000 00 0000 0000 0000010 00000 ff 0000 018 000
5 1 000001 00 0000 0000 00 0000 0000 1000111 60006 60 0000 019 000
5 6 000001 00 0000 1000 00 0000 0000 0000010 00000 ff 0000 01f 000
5 1 000000 00 1010 1000 4b 8400 0000 0000010 00000 4b 0000 020 000
5 2 000001 00 0000 1000 00 0000 0000 0000010 00000 ff 0000 022 000
5 1 000001 00 0000 1000 00 0000 0000 1000111 60006 60 0000 023 000
6 1 000000 00 1010 0000 4b 0200 0000 0000011 00000 4b 0000 024 000
6 1 001111 00 0000 0000 00 0000 0000 0000011 00000 ff 0000 025 000
// beam timing across the line wrap
7 19f 000000 00 0000 0000 00 0000 0000 0000011 00000 ff 0000 1c4 000
7 1 000000 00 0000 0000 00 0000 0000 0000011 00000 ff 0000 1c5 100
7 1 000000 00 0000 0000 00 0000 0000 0000011 00000 ff 0000 000 000
7 1 000000 00 0000 0000 00 0000 0000 1000010 00000 ff 0000 001 000
7 a 000000 00 0000 0000 00 0000 0000 0000011 00000 ff 0000 00b 010

// ==== filelist.f ====
common/agnus_pkg.sv
common/dma_enable_if.sv
dma/dma_control.sv
dma/dma_arbiter.sv
hdl/beam_counter.sv
hdl/agnus_bus.sv
test/agnus_bus_tb.sv

// ==== Makefile ====
# Verilator build for the agnus chip bus core

VERILATOR ?= verilator
TOP       ?= agnus_bus_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --binary -j 0

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/agnus_bus_tb.sv ====
// agnus chip bus testbench
// replays per cycle vectors from a data file against the bus core,
// checking grants, bus mux, dmacon readback and beam strobes

`timescale 1ns/1ps

module agnus_bus_tb;

	localparam int TOKENS    = 15;	// words per vector line
	localparam int MAX_LINES = 64;

	logic clk;
	logic reset;

	// dut inputs
	logic                              dma_dsk, dma_aud, dma_bpl;
	logic                              req_spr, req_cop, req_blt;
	logic                              wr_dsk, we_blt;
	logic [agnus_pkg::CHIP_ADDR_W-1:0] address_dsk, address_aud, address_bpl;
	logic [agnus_pkg::CHIP_ADDR_W-1:0] address_spr, address_cop, address_blt;
	logic [agnus_pkg::REG_ADDR_W-1:0]  reg_address_dsk, reg_address_aud, reg_address_bpl;
	logic [agnus_pkg::REG_ADDR_W-1:0]  reg_address_spr, reg_address_cop, reg_address_blt;
	logic                              aen, rd, hwr, lwr;
	logic [agnus_pkg::REG_ADDR_W-1:0]  address_in;
	logic                              bls, turbo;
	logic [agnus_pkg::DATA_W-1:0]      data_in;
	logic                              blit_busy, blit_zero;
	logic [agnus_pkg::DATA_W-1:0]      data_blt;

	// dut outputs
	logic [agnus_pkg::DATA_W-1:0]      data_out;
	logic [agnus_pkg::HPOS_W-1:0]      hpos;
	logic                              sol, strhor_denise, strhor_paula;
	logic                              ack_spr, ack_cop, ack_blt, ena_cop, ena_blt;
	logic                              dbr, dbwe;
	logic [agnus_pkg::CHIP_ADDR_W-1:0] address_out;
	logic [agnus_pkg::REG_ADDR_W-1:0]  reg_address;

	logic [31:0] vec_mem [0:TOKENS*MAX_LINES-1];	// flat token store

	int num_lines;
	int total_cycles;
	int errors;
	int test_errors;
	int test_checks;
	int tests_done;
	int cur_test;

	agnus_bus agnus_bus_inst (.*);

	always #4 clk = ~clk;	// 8 ns bus slot

	// ------------------------------------------------------------------
	// vector helpers

	function automatic logic [31:0] token(input int line, input int k);
		return vec_mem[line*TOKENS + k];
	endfunction

	// multi digit columns hold one bit per hex digit, leftmost first
	function automatic logic digit(input logic [31:0] tok, input int n, input int k);
		return tok[4*(n-1-k)];
	endfunction

	function automatic string test_name(input int num);
		case (num)
			1:       return "dmacon set and readback";
			2:       return "priority order";
			3:       return "cpu pass-through";
			4:       return "dmacon clear";
			5:       return "blitter slowdown";
			6:       return "master enable off";
			7:       return "beam timing";
			default: return "unnamed";
		endcase
	endfunction

	task automatic drive_line(input int l);
		logic [31:0] chan;
		logic [31:0] wr;
		logic [31:0] cpu;
		logic [31:0] misc;
		logic [31:0] adin;
		logic [31:0] dain;
		logic [31:0] dblt;
		chan = token(l, 2);
		wr   = token(l, 3);
		cpu  = token(l, 4);
		misc = token(l, 5);
		adin = token(l, 6);
		dain = token(l, 7);
		dblt = token(l, 8);
		dma_dsk    <= digit(chan, 6, 0);
		dma_aud    <= digit(chan, 6, 1);
		dma_bpl    <= digit(chan, 6, 2);
		req_spr    <= digit(chan, 6, 3);
		req_cop    <= digit(chan, 6, 4);
		req_blt    <= digit(chan, 6, 5);
		wr_dsk     <= digit(wr, 2, 0);
		we_blt     <= digit(wr, 2, 1);
		aen        <= digit(cpu, 4, 0);
		rd         <= digit(cpu, 4, 1);
		hwr        <= digit(cpu, 4, 2);
		lwr        <= digit(cpu, 4, 3);
		bls        <= digit(misc, 4, 0);
		turbo      <= digit(misc, 4, 1);
		blit_busy  <= digit(misc, 4, 2);
		blit_zero  <= digit(misc, 4, 3);
		address_in <= adin[7:0];
		data_in    <= dain[15:0];
		data_blt   <= dblt[15:0];
	endtask

	task automatic check_value(input int l, input string what,
		input logic [31:0] exp, input logic [31:0] act);
		test_checks++;
		assert (exp === act)
		else
		begin
			$display("FAILED test %0d (%s) line %0d %s: expected %0h, actual %0h",
				cur_test, test_name(cur_test), l + 1, what, exp, act);
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_line(input int l);
		logic [31:0] grant;
		logic [31:0] aout;
		logic [31:0] rout;
		logic [31:0] dout;
		logic [31:0] hexp;
		logic [31:0] beam;
		grant = token(l, 9);
		aout  = token(l, 10);
		rout  = token(l, 11);
		dout  = token(l, 12);
		hexp  = token(l, 13);
		beam  = token(l, 14);
		check_value(l, "dbr",     {31'd0, digit(grant, 7, 0)}, {31'd0, dbr});
		check_value(l, "dbwe",    {31'd0, digit(grant, 7, 1)}, {31'd0, dbwe});
		check_value(l, "ack_spr", {31'd0, digit(grant, 7, 2)}, {31'd0, ack_spr});
		check_value(l, "ack_cop", {31'd0, digit(grant, 7, 3)}, {31'd0, ack_cop});
		check_value(l, "ack_blt", {31'd0, digit(grant, 7, 4)}, {31'd0, ack_blt});
		check_value(l, "ena_cop", {31'd0, digit(grant, 7, 5)}, {31'd0, ena_cop});
		check_value(l, "ena_blt", {31'd0, digit(grant, 7, 6)}, {31'd0, ena_blt});
		check_value(l, "address_out", {12'd0, aout[19:0]}, {12'd0, address_out});
		check_value(l, "reg_address", {24'd0, rout[7:0]}, {24'd0, reg_address});
		check_value(l, "data_out", {16'd0, dout[15:0]}, {16'd0, data_out});
		check_value(l, "hpos", {23'd0, hexp[8:0]}, {23'd0, hpos});
		check_value(l, "sol",           {31'd0, digit(beam, 3, 0)}, {31'd0, sol});
		check_value(l, "strhor_denise", {31'd0, digit(beam, 3, 1)}, {31'd0, strhor_denise});
		check_value(l, "strhor_paula",  {31'd0, digit(beam, 3, 2)}, {31'd0, strhor_paula});
	endtask

	task automatic report_test();
		if (test_errors == 0)
			$display("test %0d %s: ok, %0d checks", cur_test, test_name(cur_test), test_checks);
		else
			$display("test %0d %s: %0d of %0d checks wrong", cur_test, test_name(cur_test),
				test_errors, test_checks);
		tests_done++;
		test_errors = 0;
		test_checks = 0;
	endtask

	// ------------------------------------------------------------------
	// watchdog, sized from the vector lengths

	initial
	begin
		wait (total_cycles > 0);
		#((total_cycles + 10 + 20) * 8 + 100);
		$display("timeout: vectors did not finish in the expected time");
		$display("Checks failed");
		$finish;
	end

	// ------------------------------------------------------------------
	// main sequence

	initial
	begin
		int cnt;
		int tnum;
		clk   = 1'b0;
		reset = 1'b1;
		{dma_dsk, dma_aud, dma_bpl, req_spr, req_cop, req_blt} = '0;
		{wr_dsk, we_blt, aen, rd, hwr, lwr, bls, turbo} = '0;
		{blit_busy, blit_zero} = '0;
		address_in = '0;
		data_in    = '0;
		data_blt   = '0;
		// every channel gets its own address so the mux winner is visible
		address_dsk = 20'h10001;
		address_aud = 20'h20002;
		address_bpl = 20'h30003;
		address_spr = 20'h40004;
		address_cop = 20'h50005;
		address_blt = 20'h60006;
		reg_address_dsk = 8'h10;
		reg_address_aud = 8'h20;
		reg_address_bpl = 8'h30;
		reg_address_spr = 8'h40;
		reg_address_cop = 8'h50;
		reg_address_blt = 8'h60;
		errors       = 0;
		test_errors  = 0;
		test_checks  = 0;
		tests_done   = 0;
		cur_test     = 0;
		num_lines    = 0;
		total_cycles = 0;

		$readmemh("test/agnus_vectors.mem", vec_mem);
		while (num_lines < MAX_LINES && !$isunknown(token(num_lines, 0)))
		begin
			total_cycles += int'(token(num_lines, 1));
			num_lines++;
		end
		if (num_lines == 0)
		begin
			$display("no vectors could be read from test/agnus_vectors.mem");
			errors++;
		end

		repeat (10) @(posedge clk);
		reset <= 1'b0;	// first vector cycle has hpos 0

		for (int l = 0; l < num_lines; l++)
		begin
			tnum = int'(token(l, 0));
			if (tnum != cur_test)
			begin
				if (cur_test != 0)
					report_test();
				cur_test = tnum;
			end
			cnt = int'(token(l, 1));
			for (int j = 0; j < cnt; j++)
			begin
				drive_line(l);
				@(negedge clk);	// outputs settled mid slot
				if (j == cnt - 1)
					check_line(l);
				@(posedge clk);
			end
		end
		if (cur_test != 0)
			report_test();

		$display("%0d tests, %0d vector lines, %0d errors", tests_done, num_lines, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// ==== hdl/agnus_bus.sv ====
// agnus chip bus core
// joins the beam counter, the dmacon register and the bus arbiter,
// with the dma engines and blitter left outside as plain ports

`timescale 1ns/1ps

module agnus_bus (
	input  logic                              clk,
	input  logic                              reset,
	// dma channels
	input  logic                              dma_dsk,	// disk uses its slot
	input  logic                              dma_aud,	// audio uses its slot
	input  logic                              dma_bpl,	// bitplanes use their slot
	input  logic                              req_spr,
	input  logic                              req_cop,
	input  logic                              req_blt,
	input  logic                              wr_dsk,
	input  logic                              we_blt,
	input  logic [agnus_pkg::CHIP_ADDR_W-1:0] address_dsk,
	input  logic [agnus_pkg::CHIP_ADDR_W-1:0] address_aud,
	input  logic [agnus_pkg::CHIP_ADDR_W-1:0] address_bpl,
	input  logic [agnus_pkg::CHIP_ADDR_W-1:0] address_spr,
	input  logic [agnus_pkg::CHIP_ADDR_W-1:0] address_cop,
	input  logic [agnus_pkg::CHIP_ADDR_W-1:0] address_blt,
	input  logic [agnus_pkg::REG_ADDR_W-1:0]  reg_address_dsk,
	input  logic [agnus_pkg::REG_ADDR_W-1:0]  reg_address_aud,
	input  logic [agnus_pkg::REG_ADDR_W-1:0]  reg_address_bpl,
	input  logic [agnus_pkg::REG_ADDR_W-1:0]  reg_address_spr,
	input  logic [agnus_pkg::REG_ADDR_W-1:0]  reg_address_cop,
	input  logic [agnus_pkg::REG_ADDR_W-1:0]  reg_address_blt,
	// cpu side
	input  logic                              aen,	// register bank select
	input  logic                              rd,
	input  logic                              hwr,
	input  logic                              lwr,
	input  logic [agnus_pkg::REG_ADDR_W-1:0]  address_in,
	input  logic                              bls,	// cpu waiting for the bus
	input  logic                              turbo,
	// data
	input  logic [agnus_pkg::DATA_W-1:0]      data_in,
	input  logic                              blit_busy,
	input  logic                              blit_zero,
	input  logic [agnus_pkg::DATA_W-1:0]      data_blt,	// blitter register readback
	output logic [agnus_pkg::DATA_W-1:0]      data_out,
	// beam
	output logic [agnus_pkg::HPOS_W-1:0]      hpos,
	output logic                              sol,
	output logic                              strhor_denise,
	output logic                              strhor_paula,
	// bus grant
	output logic                              ack_spr,
	output logic                              ack_cop,
	output logic                              ack_blt,
	output logic                              ena_cop,
	output logic                              ena_blt,
	output logic                              dbr,
	output logic                              dbwe,
	output logic [agnus_pkg::CHIP_ADDR_W-1:0] address_out,
	output logic [agnus_pkg::REG_ADDR_W-1:0]  reg_address
);

	logic                          cck;	// colour clock phase
	logic                          refresh;	// refresh slot
	logic [agnus_pkg::DATA_W-1:0]  dmaconr_data;

	dma_enable_if dma_en ();	// dmacon enables to the arbiter

	// ----------------------------------------------------------------------
	// beam timing

	beam_counter beam_counter_inst (
		.clk           (clk),
		.reset         (reset),
		.hpos          (hpos),
		.cck           (cck),
		.refresh       (refresh),
		.sol           (sol),
		.strhor_denise (strhor_denise),
		.strhor_paula  (strhor_paula)
	);

	// dmacon decoded from the arbitrated register bus
	dma_control dma_control_inst (
		.clk          (clk),
		.reset        (reset),
		.reg_address  (reg_address),
		.data_in      (data_in),
		.blit_busy    (blit_busy),
		.blit_zero    (blit_zero),
		.dmaconr_data (dmaconr_data),
		.en           (dma_en)
	);

	dma_arbiter dma_arbiter_inst (
		.clk             (clk),
		.reset           (reset),
		.cck             (cck),
		.turbo           (turbo),
		.bls             (bls),
		.refresh         (refresh),
		.en              (dma_en),
		.dma_dsk         (dma_dsk),
		.dma_aud         (dma_aud),
		.dma_bpl         (dma_bpl),
		.req_spr         (req_spr),
		.req_cop         (req_cop),
		.req_blt         (req_blt),
		.wr_dsk          (wr_dsk),
		.we_blt          (we_blt),
		.aen             (aen),
		.rd              (rd),
		.hwr             (hwr),
		.lwr             (lwr),
		.address_dsk     (address_dsk),
		.address_aud     (address_aud),
		.address_bpl     (address_bpl),
		.address_spr     (address_spr),
		.address_cop     (address_cop),
		.address_blt     (address_blt),
		.reg_address_dsk (reg_address_dsk),
		.reg_address_aud (reg_address_aud),
		.reg_address_bpl (reg_address_bpl),
		.reg_address_spr (reg_address_spr),
		.reg_address_cop (reg_address_cop),
		.reg_address_blt (reg_address_blt),
		.address_in      (address_in),
		.ack_spr         (ack_spr),
		.ack_cop         (ack_cop),
		.ack_blt         (ack_blt),
		.ena_cop         (ena_cop),
		.ena_blt         (ena_blt),
		.dbr             (dbr),
		.dbwe            (dbwe),
		.address_out     (address_out),
		.reg_address     (reg_address)
	);

	// readback sources drive 0 when not addressed
	assign data_out = dmaconr_data | data_blt;

endmodule

// ==== hdl/beam_counter.sv ====
// horizontal beam counter
// counts bus slots across one video line and decodes colour clock
// phase, refresh slots, start of line and the horizontal strobes

`timescale 1ns/1ps

module beam_counter (
	input  logic                         clk,
	input  logic                         reset,
	output logic [agnus_pkg::HPOS_W-1:0] hpos,	// slot within the line
	output logic                         cck,	// odd slots belong to the chipset
	output logic                         refresh,	// memory refresh slot
	output logic                         sol,	// last slot, next one starts a line
	output logic                         strhor_denise,	// horizontal strobe for video
	output logic                         strhor_paula	// horizontal strobe for audio
);

	logic line_end;	// wrap point

	// ----------------------------------------------------------------------
	// slot counter

	assign line_end = (hpos == agnus_pkg::LINE_LAST);

	always_ff @(posedge clk)
	begin
		if (reset)
			hpos <= '0;
		else if (line_end)
			hpos <= '0;	// fixed line length
		else
			hpos <= hpos + 1'b1;	// one slot per clk
	end

	// ----------------------------------------------------------------------
	// slot decodes

	assign cck = hpos[0];

	// refresh owns a few odd slots at the start of the line
	assign refresh = hpos[0]
		&& (hpos >= agnus_pkg::REFRESH_FIRST)
		&& (hpos <= agnus_pkg::REFRESH_LAST);

	assign sol = line_end;	// high during the last slot of the line

	// single slot strobes
	assign strhor_denise = (hpos == agnus_pkg::STRHOR_DENISE_POS);
	assign strhor_paula  = (hpos == agnus_pkg::STRHOR_PAULA_POS);

endmodule

// ==== dma/dma_arbiter.sv ====
// chip bus arbiter
// fixed priority grant of the chip bus to the dma channels, with the
// cpu taking whatever is left, plus the blitter slowdown counter

`timescale 1ns/1ps

module dma_arbiter (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              cck,	// colour clock phase
	input  logic                              turbo,	// blitter may use every slot
	input  logic                              bls,	// cpu is waiting for the bus
	input  logic                              refresh,	// refresh slot
	dma_enable_if.arb                         en,
	// channel slot use and requests
	input  logic                              dma_dsk,
	input  logic                              dma_aud,
	input  logic                              dma_bpl,
	input  logic                              req_spr,
	input  logic                              req_cop,
	input  logic                              req_blt,
	// write enables and cpu strobes
	input  logic                              wr_dsk,
	input  logic                              we_blt,
	input  logic                              aen,
	input  logic                              rd,
	input  logic                              hwr,
	input  logic                              lwr,
	// channel chip addresses
	input  logic [agnus_pkg::CHIP_ADDR_W-1:0] address_dsk,
	input  logic [agnus_pkg::CHIP_ADDR_W-1:0] address_aud,
	input  logic [agnus_pkg::CHIP_ADDR_W-1:0] address_bpl,
	input  logic [agnus_pkg::CHIP_ADDR_W-1:0] address_spr,
	input  logic [agnus_pkg::CHIP_ADDR_W-1:0] address_cop,
	input  logic [agnus_pkg::CHIP_ADDR_W-1:0] address_blt,
	// channel register addresses
	input  logic [agnus_pkg::REG_ADDR_W-1:0]  reg_address_dsk,
	input  logic [agnus_pkg::REG_ADDR_W-1:0]  reg_address_aud,
	input  logic [agnus_pkg::REG_ADDR_W-1:0]  reg_address_bpl,
	input  logic [agnus_pkg::REG_ADDR_W-1:0]  reg_address_spr,
	input  logic [agnus_pkg::REG_ADDR_W-1:0]  reg_address_cop,
	input  logic [agnus_pkg::REG_ADDR_W-1:0]  reg_address_blt,
	input  logic [agnus_pkg::REG_ADDR_W-1:0]  address_in,	// cpu register address
	// grants and bus
	output logic                              ack_spr,
	output logic                              ack_cop,
	output logic                              ack_blt,
	output logic                              ena_cop,	// nothing above copper is active
	output logic                              ena_blt,	// nothing above blitter is active
	output logic                              dbr,	// agnus owns the data bus
	output logic                              dbwe,	// dma write cycle
	output logic [agnus_pkg::CHIP_ADDR_W-1:0] address_out,
	output logic [agnus_pkg::REG_ADDR_W-1:0]  reg_address
);

	logic [1:0]                        bls_cnt;	// cpu missed cycles
	logic                              bls_ok;	// blitter not held off
	logic                              slot_bpl;	// bitplane slot in use
	logic                              dma_spr;
	logic                              dma_cop;
	logic                              dma_blt;
	logic [agnus_pkg::REG_ADDR_W-1:0]  reg_address_cpu;

	// ----------------------------------------------------------------------
	// channel qualifiers

	assign slot_bpl = dma_bpl & en.bplen;	// bitplane fetch only with its dma on
	assign dma_spr  = req_spr & en.spren;
	assign dma_cop  = req_cop & en.copen;
	assign dma_blt  = req_blt & en.blten;
	assign bls_ok   = (bls_cnt != agnus_pkg::BLS_CNT_MAX);

	// cpu only drives a register address during a real access
	assign reg_address_cpu = (aen && (rd || hwr || lwr)) ? address_in : agnus_pkg::REG_IDLE;

	// ----------------------------------------------------------------------
	// priority grant and bus mux, first match wins

	always_comb
	begin
		dbr         = 1'b1;	// some dma channel owns the bus
		dbwe        = 1'b0;
		ack_spr     = 1'b0;
		ack_cop     = 1'b0;
		ack_blt     = 1'b0;
		address_out = '0;
		reg_address = agnus_pkg::REG_IDLE;
		if (dma_dsk)
		begin
			address_out = address_dsk;
			reg_address = reg_address_dsk;
			dbwe        = wr_dsk;	// disk reads write to chip ram
		end
		else if (refresh)
		begin
			// refresh cycle, address 0 and no register
		end
		else if (dma_aud)
		begin
			address_out = address_aud;
			reg_address = reg_address_aud;
		end
		else if (slot_bpl)
		begin
			address_out = address_bpl;
			reg_address = reg_address_bpl;
		end
		else if (dma_spr)
		begin
			ack_spr     = 1'b1;
			address_out = address_spr;
			reg_address = reg_address_spr;
		end
		else if (dma_cop)
		begin
			ack_cop     = 1'b1;
			address_out = address_cop;
			reg_address = reg_address_cop;
		end
		else if (dma_blt && bls_ok)
		begin
			ack_blt     = 1'b1;
			address_out = address_blt;
			reg_address = reg_address_blt;
			dbwe        = we_blt;
		end
		else
		begin
			dbr         = 1'b0;	// bus left to the cpu
			reg_address = reg_address_cpu;
		end
	end

	// ----------------------------------------------------------------------
	// blitter slowdown

	// counts memory cycles in which the cpu waits while the blitter runs
	always_ff @(posedge clk)
	begin
		if (reset)
			bls_cnt <= 2'd0;
		else if (!cck || turbo)
		begin
			if (!bls || en.bltpri)
				bls_cnt <= 2'd0;	// cpu got through, or nasty mode
			else if (bls_ok)
				bls_cnt <= bls_cnt + 2'd1;	// saturates at the limit
		end
	end

	// copper slots can only be taken by bitplanes above it
	assign ena_cop = ~slot_bpl;

	// blitter is last in line, anything active above it blocks it
	assign ena_blt = ~(refresh | dma_dsk | dma_aud | slot_bpl | dma_spr | dma_cop) & bls_ok;

endmodule

// ==== dma/dma_control.sv ====
// dma control register
// dmacon set/clear write, dmaconr readback with blitter status,
// and the per channel enables gated by the master enable

`timescale 1ns/1ps

module dma_control (
	input  logic                             clk,
	input  logic                             reset,
	input  logic [agnus_pkg::REG_ADDR_W-1:0] reg_address,	// multiplexed register bus
	input  logic [agnus_pkg::DATA_W-1:0]     data_in,
	input  logic                             blit_busy,	// blitter status
	input  logic                             blit_zero,
	output logic [agnus_pkg::DATA_W-1:0]     dmaconr_data,	// or-ed onto data out
	dma_enable_if.ctrl                       en
);

	logic [agnus_pkg::DMACON_BITS-1:0] dmacon;	// stored enable bits
	agnus_pkg::dmacon_word_u           wr_word;	// write view of data_in
	agnus_pkg::dmacon_word_u           rd_word;	// read word
	logic                              dmacon_wr;
	logic                              dmaen;	// master enable

	// ----------------------------------------------------------------------
	// write decode

	assign dmacon_wr   = (reg_address == agnus_pkg::REG_DMACON);
	assign wr_word.raw = data_in;

	always_ff @(posedge clk)
	begin
		if (reset)
			dmacon <= '0;	// all dma off
		else if (dmacon_wr)
		begin
			if (wr_word.fields.setclr)
				dmacon <= dmacon | wr_word.fields.en;	// set the given bits
			else
				dmacon <= dmacon & ~wr_word.fields.en;	// clear them
		end
	end

	// ----------------------------------------------------------------------
	// readback

	// bit 15 reads 0, then busy and zero, then the stored bits
	always_comb
	begin
		if (reg_address == agnus_pkg::REG_DMACONR)
			rd_word.raw = {1'b0, blit_busy, blit_zero, dmacon};
		else
			rd_word.raw = '0;	// other registers, keep out of the data or
	end

	assign dmaconr_data = rd_word.raw;

	// ----------------------------------------------------------------------
	// channel enables

	assign dmaen = dmacon[agnus_pkg::DMAEN_BIT];

	// nasty bit acts on its own, not through dmaen
	assign en.bltpri = dmacon[agnus_pkg::BLTPRI_BIT];

	assign en.bplen = dmacon[agnus_pkg::BPLEN_BIT] & dmaen;
	assign en.copen = dmacon[agnus_pkg::COPEN_BIT] & dmaen;
	assign en.blten = dmacon[agnus_pkg::BLTEN_BIT] & dmaen;
	assign en.spren = dmacon[agnus_pkg::SPREN_BIT] & dmaen;

endmodule

// ==== common/dma_enable_if.sv ====
// dma channel enables
// levels decoded from dmacon, driven by the control register and
// read by the bus arbiter

`timescale 1ns/1ps

interface dma_enable_if;

	logic bltpri;	// blitter nasty, raw dmacon bit
	logic bplen;	// bitplane dma enabled
	logic copen;	// copper dma enabled
	logic blten;	// blitter dma enabled
	logic spren;	// sprite dma enabled

	// control register side
	modport ctrl (
		output bltpri, bplen, copen, blten, spren
	);

	// arbiter side
	modport arb (
		input bltpri, bplen, copen, blten, spren
	);

endinterface

// ==== common/agnus_pkg.sv ====
// agnus chip bus package
// bus widths, register offsets, beam slot positions and the
// dmacon word layout shared by the arbitration core

package agnus_pkg;

	// ----------------------------------------------------------------------
	// bus widths
	localparam int DATA_W      = 16;	// chip data bus
	localparam int CHIP_ADDR_W = 20;	// chip ram word address
	localparam int REG_ADDR_W  = 8;	// custom register word address
	localparam int HPOS_W      = 9;	// horizontal beam counter

	// ----------------------------------------------------------------------
	// register word offsets (byte offset with bit 0 dropped)
	localparam logic [REG_ADDR_W-1:0] REG_IDLE    = '1;	// no register selected
	localparam logic [REG_ADDR_W-1:0] REG_DMACON  = 8'h4B;	// 0x096 write
	localparam logic [REG_ADDR_W-1:0] REG_DMACONR = 8'h01;	// 0x002 read

	// ----------------------------------------------------------------------
	// dmacon layout
	localparam int DMACON_BITS = 13;	// stored enable bits [12:0]

	localparam int DMAEN_BIT  = 9;	// master dma enable
	localparam int BLTPRI_BIT = 10;	// blitter nasty
	localparam int BPLEN_BIT  = 8;	// bitplane dma
	localparam int COPEN_BIT  = 7;	// copper dma
	localparam int BLTEN_BIT  = 6;	// blitter dma
	localparam int SPREN_BIT  = 5;	// sprite dma

	// blitter gives up the bus after the cpu missed it this many times
	localparam logic [1:0] BLS_CNT_MAX = 2'd3;

	// ----------------------------------------------------------------------
	// horizontal slot positions
	localparam logic [HPOS_W-1:0] LINE_LAST = 9'd453;	// last slot of a line

	// refresh takes the odd slots in this range
	localparam logic [HPOS_W-1:0] REFRESH_FIRST = 9'd1;
	localparam logic [HPOS_W-1:0] REFRESH_LAST  = 9'd7;

	localparam logic [HPOS_W-1:0] STRHOR_DENISE_POS = 9'd11;	// 6*2-1
	localparam logic [HPOS_W-1:0] STRHOR_PAULA_POS  = 9'd13;	// 6*2+1

	// ----------------------------------------------------------------------
	// dmacon write layout: bit 15 selects set or clear, 14:13 not stored
	typedef struct packed {
		logic                   setclr;	// 1 = set, 0 = clear
		logic [1:0]             spare;	// ignored on write
		logic [DMACON_BITS-1:0] en;	// enable bits to set or clear
	} dmacon_fields_t;

	// one data word, seen raw or split into dmacon fields
	typedef union packed {
		logic [DATA_W-1:0] raw;
		dmacon_fields_t    fields;
	} dmacon_word_u;

endpackage
